// File: design/vctrl_defines.svh
`ifndef VCTRL_DEFINES_SVH
`define VCTRL_DEFINES_SVH

// Vector register size in bytes (VLEN = 128)
`define VREG_BYTES 16
// Downstream micro-op slots
`define NUM_CREDITS 4
// Scalar datapath width
`define XLEN 32
// Upper bound on micro-ops per instruction
`define MAX_UOPS 8
// Architectural register index width
`define REGIDX_W 5

`endif

// File: design/vinstr_pkg.sv
`include "vctrl_defines.svh"

package vinstr_pkg;

    // Major opcodes of the vector extension
    typedef enum logic [6:0] {
        VMOC_LOAD    = 7'b0000111,
        VMOC_STORE   = 7'b0100111,
        VMOC_ALU_CFG = 7'b1010111,
        VMOC_INVALID = 7'b1111111
    } vmajor_t;

    // Load/store addressing mode
    typedef enum logic [1:0] {
        MOP_UNIT     = 2'b00,
        MOP_UINDEXED = 2'b01,
        MOP_STRIDED  = 2'b10,
        MOP_OINDEXED = 2'b11
    } mop_t;

    // Unit-stride variants, held in the rs2 field
    typedef enum logic [4:0] {
        LUMOP_UNIT    = 5'b00000,
        LUMOP_FULLREG = 5'b01000,
        LUMOP_MASK    = 5'b01011
    } lumop_t;

    // Arithmetic and config formats
    typedef enum logic [2:0] {
        OPIVV, OPFVV, OPMVV, OPIVI, OPIVX, OPFVF, OPMVX, OPCFG
    } vfunct3_t;

    typedef enum logic [1:0] {
        NOT_CFG, VSETVLI, VSETIVLI, VSETVL
    } vset_type_t;

    // Memory width field, same bits as funct3
    typedef logic [2:0]           vwidth_t;
    typedef logic [`REGIDX_W-1:0] regidx_t;
    typedef logic [5:0]           funct6_t;
    typedef logic [31:0]          instr_t;

endpackage

// File: design/vuop_pkg.sv
`include "vctrl_defines.svh"

package vuop_pkg;

    // Element width as log2 of the byte count
    typedef enum logic [2:0] {
        SEW8  = 3'd0,
        SEW16 = 3'd1,
        SEW32 = 3'd2
    } vsew_t;

    // Register grouping code from vtype
    typedef logic [2:0] vlmul_t;

    // Element count after mask and whole-register scaling
    typedef logic [`XLEN-1:0] evl_t;

    // Micro-op count, or index within an instruction
    typedef logic [3:0] uop_cnt_t;

    // Holds 0 to NUM_CREDITS
    typedef logic [2:0] credit_t;

    typedef enum logic {
        SEQ_IDLE,
        SEQ_ISSUE
    } seq_state_t;

endpackage

// File: design/vdec_if.sv
`timescale 1ns/1ps
`include "vctrl_defines.svh"

interface vdec_if import vinstr_pkg::*, vuop_pkg::*; ();

    // Raw fields and classification
    logic       is_vector;
    vmajor_t    major;
    mop_t       mop;
    lumop_t     lumop;
    vwidth_t    mem_width;
    vfunct3_t   funct3;
    funct6_t    funct6;
    regidx_t    vd, vs1, vs2;
    uop_cnt_t   nf;
    vset_type_t vset_type;
    logic       keepvl;

    // Register file and operand control
    logic sregwen, vregwen;
    logic use_imm, use_rs1, use_rs2;
    logic vmask_ldst, vwholereg, vindexed;

    // Width results
    vsew_t    eew_src1, eew_src2, eew_dest;
    evl_t     evl;
    uop_cnt_t uop_count;

    modport decoder (
        output is_vector, major, mop, lumop, mem_width, funct3, funct6,
               vd, vs1, vs2, nf, vset_type, keepvl, sregwen, vregwen,
               use_imm, use_rs1, use_rs2, vmask_ldst, vwholereg, vindexed
    );

    modport width (
        input  is_vector, major, mop, lumop, mem_width, funct3, funct6,
               vd, vs1, vs2, nf, vset_type, keepvl, sregwen, vregwen,
               use_imm, use_rs1, use_rs2, vmask_ldst, vwholereg, vindexed,
        output eew_src1, eew_src2, eew_dest, evl, uop_count
    );

    modport seq (
        input is_vector, major, mop, lumop, mem_width, funct3, funct6,
              vd, vs1, vs2, nf, vset_type, keepvl, sregwen, vregwen,
              use_imm, use_rs1, use_rs2, vmask_ldst, vwholereg, vindexed,
              eew_src1, eew_src2, eew_dest, evl, uop_count
    );

endinterface

// File: design/vinstr_decode.sv
`timescale 1ns/1ps
`include "vctrl_defines.svh"

module vinstr_decode import vinstr_pkg::*; (
    input instr_t   instr,
    vdec_if.decoder dec
);

    vmajor_t  major;
    vfunct3_t funct3;
    mop_t     mop;
    lumop_t   lumop;
    regidx_t  rd, rs1;
    logic     is_load, is_store, is_mem, is_cfg;

    // Scalar views of the register fields
    assign rd  = instr[11:7];
    assign rs1 = instr[19:15];

    // Only the three vector opcodes are recognised
    always_comb begin
        case (instr[6:0])
            VMOC_LOAD:    major = VMOC_LOAD;
            VMOC_STORE:   major = VMOC_STORE;
            VMOC_ALU_CFG: major = VMOC_ALU_CFG;
            default:      major = VMOC_INVALID;
        endcase
    end

    assign funct3   = vfunct3_t'(instr[14:12]);
    assign mop      = mop_t'(instr[27:26]);
    assign lumop    = lumop_t'(instr[24:20]);
    assign is_load  = (major == VMOC_LOAD);
    assign is_store = (major == VMOC_STORE);
    assign is_mem   = is_load || is_store;
    assign is_cfg   = (major == VMOC_ALU_CFG) && (funct3 == OPCFG);

    assign dec.is_vector = (major != VMOC_INVALID);
    assign dec.major     = major;
    assign dec.mop       = mop;
    assign dec.lumop     = lumop;
    assign dec.mem_width = instr[14:12];
    assign dec.funct3    = funct3;
    // Passed through untouched for the executor
    assign dec.funct6    = instr[31:26];
    // nf field is stored minus one
    assign dec.nf        = {1'b0, instr[31:29]} + 4'd1;

    // Store data register vs3 sits in the vd field
    assign dec.vd  = instr[11:7];
    assign dec.vs1 = is_store ? instr[11:7] : instr[19:15];
    assign dec.vs2 = instr[24:20];

    // vset* flavour from the top two bits
    always_comb begin
        dec.vset_type = NOT_CFG;
        dec.keepvl    = 1'b0;
        if (is_cfg) begin
            casez (instr[31:30])
                2'b0?: begin
                    dec.vset_type = VSETVLI;
                    dec.keepvl    = (rs1 == '0) && (rd == '0);
                end
                2'b11: dec.vset_type = VSETIVLI;
                2'b10: begin
                    dec.vset_type = VSETVL;
                    dec.keepvl    = (rs1 == '0) && (rd == '0);
                end
                default: dec.vset_type = NOT_CFG;
            endcase
        end
    end

    // Memory addressing flavours
    assign dec.vindexed   = is_mem && ((mop == MOP_UINDEXED) || (mop == MOP_OINDEXED));
    assign dec.vmask_ldst = is_mem && (mop == MOP_UNIT) && (lumop == LUMOP_MASK);
    assign dec.vwholereg  = is_mem && (mop == MOP_UNIT) && (lumop == LUMOP_FULLREG);

    // vset* writes the new vl to rd
    assign dec.sregwen = is_cfg;
    assign dec.vregwen = (major != VMOC_INVALID) && !is_store && !is_cfg;

    // Operand selects
    assign dec.use_imm = (major == VMOC_ALU_CFG) && (funct3 == OPIVI);
    assign dec.use_rs1 = is_mem ||
                         ((major == VMOC_ALU_CFG) &&
                          ((funct3 == OPIVX) || (funct3 == OPFVF) || (funct3 == OPMVX)));
    // rs2 carries the stride, indexed ops take vs2 instead
    assign dec.use_rs2 = is_mem && !dec.vindexed;

endmodule

// File: design/vwidth_calc.sv
`timescale 1ns/1ps
`include "vctrl_defines.svh"

module vwidth_calc import vinstr_pkg::*, vuop_pkg::*; (
    input evl_t   vl,
    input vsew_t  vsew,
    vdec_if.width dec
);

    logic             is_mem, widening;
    vsew_t            mem_eew, twice_vsew, eew_dest;
    evl_t             mask_evl, wholereg_evl, evl;
    // Room for evl scaled by up to 8 bytes per element
    logic [`XLEN+2:0] evl_bytes, reg_span;

    assign is_mem     = (dec.major == VMOC_LOAD) || (dec.major == VMOC_STORE);
    assign twice_vsew = vsew_t'(vsew + 3'd1);
    // funct6 top bits 11 mark the widening group
    assign widening   = (dec.major == VMOC_ALU_CFG) && (dec.funct3 != OPCFG) &&
                        (dec.funct6[5:4] == 2'b11);

    // Width field to EEW: 8, 16, everything else 32
    always_comb begin
        case (dec.mem_width)
            3'b000:  mem_eew = SEW8;
            3'b101:  mem_eew = SEW16;
            default: mem_eew = SEW32;
        endcase
    end

    always_comb begin
        dec.eew_src1 = vsew;
        dec.eew_src2 = vsew;
        eew_dest     = vsew;
        if (widening) begin
            eew_dest = twice_vsew;
        end
        // Data side follows the memory width
        if (is_mem && !dec.vindexed) begin
            dec.eew_src1 = mem_eew;
            eew_dest     = mem_eew;
        end
        // Index vector follows the memory width
        if (is_mem && dec.vindexed) begin
            dec.eew_src2 = mem_eew;
        end
    end

    assign dec.eew_dest = eew_dest;

    // Mask ops move ceil(vl/8) bytes
    assign mask_evl     = (vl >> 3) + evl_t'(|vl[2:0]);
    // nf whole registers worth of elements
    assign wholereg_evl = (evl_t'(dec.nf) * `VREG_BYTES) >> eew_dest;
    assign evl          = dec.vmask_ldst ? mask_evl :
                          dec.vwholereg  ? wholereg_evl : vl;
    assign dec.evl      = evl;

    // Registers touched, rounded up
    assign evl_bytes = {3'b000, evl} << eew_dest;
    assign reg_span  = (evl_bytes + (`VREG_BYTES - 1)) / `VREG_BYTES;

    always_comb begin
        if (dec.vset_type != NOT_CFG) begin
            dec.uop_count = uop_cnt_t'(1);
        end else if (dec.vwholereg) begin
            dec.uop_count = dec.nf;
        end else if (reg_span == '0) begin
            // vl of zero still issues one micro-op
            dec.uop_count = uop_cnt_t'(1);
        end else if (reg_span > `MAX_UOPS) begin
            dec.uop_count = uop_cnt_t'(`MAX_UOPS);
        end else begin
            dec.uop_count = uop_cnt_t'(reg_span);
        end
    end

endmodule

// File: design/vuop_seq.sv
`timescale 1ns/1ps
`include "vctrl_defines.svh"

module vuop_seq import vinstr_pkg::*, vuop_pkg::*; (
    input  logic       CLK,
    input  logic       nRST,
    input  logic       instr_valid,
    output logic       instr_ready,
    input  logic       credit_return,
    vdec_if.seq        dec,
    output logic       uop_valid,
    output logic       uop_last,
    output uop_cnt_t   uop_num,
    output regidx_t    uop_vd,
    output regidx_t    uop_vs1,
    output regidx_t    uop_vs2,
    output vsew_t      uop_eew_dest,
    output vsew_t      uop_eew_src2,
    output funct6_t    uop_funct6,
    output logic       uop_memdren,
    output logic       uop_memdwen,
    output mop_t       uop_mode,
    output logic       uop_sregwen,
    output logic       uop_vregwen,
    output logic       uop_use_imm,
    output logic       uop_use_rs1,
    output logic       uop_use_rs2,
    output vset_type_t uop_vset_type,
    output logic       uop_keepvl
);

    seq_state_t state, next_state;
    uop_cnt_t   uop_idx, cap_count;
    credit_t    credits;
    logic       accept;
    regidx_t    reg_step;

    // Copy of the accepted instruction
    regidx_t    cap_vd, cap_vs1, cap_vs2;
    vsew_t      cap_eew_dest, cap_eew_src2;
    funct6_t    cap_funct6;
    mop_t       cap_mode;
    vset_type_t cap_vset_type;
    logic       cap_memdren, cap_memdwen, cap_sregwen, cap_vregwen;
    logic       cap_use_imm, cap_use_rs1, cap_use_rs2, cap_keepvl;

    assign instr_ready = (state == SEQ_IDLE);
    assign accept      = instr_valid && instr_ready;

    // A returning credit can be reused in the same cycle
    assign uop_valid = (state == SEQ_ISSUE) && ((credits != '0) || credit_return);
    assign uop_last  = uop_valid && (uop_idx == cap_count - uop_cnt_t'(1));

    always_comb begin
        next_state = state;
        case (state)
            // Non-vector words are taken and dropped
            SEQ_IDLE:  if (accept && dec.is_vector) next_state = SEQ_ISSUE;
            SEQ_ISSUE: if (uop_last) next_state = SEQ_IDLE;
            default:   next_state = SEQ_IDLE;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state   <= SEQ_IDLE;
            uop_idx <= '0;
            credits <= credit_t'(`NUM_CREDITS);
        end else begin
            state <= next_state;
            if (accept) begin
                uop_idx <= '0;
            end else if (uop_valid) begin
                uop_idx <= uop_idx + uop_cnt_t'(1);
            end
            // One out per issue, one in per return
            case ({uop_valid, credit_return})
                2'b10:   credits <= credits - credit_t'(1);
                2'b01:   credits <= credits + credit_t'(1);
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            cap_count     <= dec.uop_count;
            cap_vd        <= dec.vd;
            cap_vs1       <= dec.vs1;
            cap_vs2       <= dec.vs2;
            cap_eew_dest  <= dec.eew_dest;
            cap_eew_src2  <= dec.eew_src2;
            cap_funct6    <= dec.funct6;
            cap_mode      <= dec.mop;
            cap_vset_type <= dec.vset_type;
            cap_memdren   <= (dec.major == VMOC_LOAD);
            cap_memdwen   <= (dec.major == VMOC_STORE);
            cap_sregwen   <= dec.sregwen;
            cap_vregwen   <= dec.vregwen;
            cap_use_imm   <= dec.use_imm;
            cap_use_rs1   <= dec.use_rs1;
            cap_use_rs2   <= dec.use_rs2;
            cap_keepvl    <= dec.keepvl;
        end
    end

    // Register groups step by the micro-op index, vset* stays put
    assign reg_step = (cap_vset_type != NOT_CFG) ? '0 : regidx_t'(uop_idx);

    assign uop_num       = uop_idx;
    assign uop_vd        = cap_vd + reg_step;
    assign uop_vs1       = cap_vs1 + reg_step;
    assign uop_vs2       = cap_vs2 + reg_step;
    assign uop_eew_dest  = cap_eew_dest;
    assign uop_eew_src2  = cap_eew_src2;
    assign uop_funct6    = cap_funct6;
    assign uop_mode      = cap_mode;
    assign uop_vset_type = cap_vset_type;
    assign uop_memdren   = cap_memdren;
    assign uop_memdwen   = cap_memdwen;
    assign uop_sregwen   = cap_sregwen;
    assign uop_vregwen   = cap_vregwen;
    assign uop_use_imm   = cap_use_imm;
    assign uop_use_rs1   = cap_use_rs1;
    assign uop_use_rs2   = cap_use_rs2;
    assign uop_keepvl    = cap_keepvl;

    // Receiver must never return more than it took
    a_credit_bound: assert property (@(posedge CLK) disable iff (!nRST)
        credit_return |-> credits < `NUM_CREDITS || uop_valid);

    // Issue on an empty counter would wrap it past the limit
    a_credit_range: assert property (@(posedge CLK) disable iff (!nRST)
        credits <= credit_t'(`NUM_CREDITS));

    // Index never runs past the captured count
    a_idx_in_range: assert property (@(posedge CLK) disable iff (!nRST)
        uop_valid |-> uop_idx < cap_count);

endmodule

// File: design/vector_control_unit.sv
`timescale 1ns/1ps
`include "vctrl_defines.svh"

module vector_control_unit import vinstr_pkg::*, vuop_pkg::*; (
    input  logic       CLK,
    input  logic       nRST,
    input  logic       instr_valid,
    output logic       instr_ready,
    input  instr_t     instr,
    input  evl_t       vl,
    input  vsew_t      vsew,
    input  logic       credit_return,
    output logic       uop_valid,
    output logic       uop_last,
    output uop_cnt_t   uop_num,
    output regidx_t    uop_vd,
    output regidx_t    uop_vs1,
    output regidx_t    uop_vs2,
    output vsew_t      uop_eew_dest,
    output vsew_t      uop_eew_src2,
    output funct6_t    uop_funct6,
    output logic       uop_memdren,
    output logic       uop_memdwen,
    output mop_t       uop_mode,
    output logic       uop_sregwen,
    output logic       uop_vregwen,
    output logic       uop_use_imm,
    output logic       uop_use_rs1,
    output logic       uop_use_rs2,
    output vset_type_t uop_vset_type,
    output logic       uop_keepvl
);

    // Decoded instruction shared by all three stages
    vdec_if dec_bus ();

    vinstr_decode u_decode (.instr(instr), .dec(dec_bus));

    vwidth_calc u_width (.vl(vl), .vsew(vsew), .dec(dec_bus));

    vuop_seq u_seq (
        .CLK(CLK), .nRST(nRST), .instr_valid(instr_valid), .instr_ready(instr_ready),
        .credit_return(credit_return), .dec(dec_bus), .uop_valid(uop_valid),
        .uop_last(uop_last), .uop_num(uop_num), .uop_vd(uop_vd), .uop_vs1(uop_vs1),
        .uop_vs2(uop_vs2), .uop_eew_dest(uop_eew_dest), .uop_eew_src2(uop_eew_src2),
        .uop_funct6(uop_funct6), .uop_memdren(uop_memdren), .uop_memdwen(uop_memdwen),
        .uop_mode(uop_mode), .uop_sregwen(uop_sregwen), .uop_vregwen(uop_vregwen),
        .uop_use_imm(uop_use_imm), .uop_use_rs1(uop_use_rs1), .uop_use_rs2(uop_use_rs2),
        .uop_vset_type(uop_vset_type), .uop_keepvl(uop_keepvl)
    );

endmodule

// File: tb/tb_vector_control_unit.sv
`timescale 1ns/1ps
`include "vctrl_defines.svh"

module tb_vector_control_unit import vinstr_pkg::*, vuop_pkg::*; ();

    localparam int MAX_LINES    = 64;
    localparam int NCOL         = 17;
    localparam int RESET_CYCLES = 8;
    // Column positions in the stimulus file
    localparam int C_INSTR = 0, C_VL = 1, C_VSEW = 2, C_DELAY = 3, C_COUNT = 4;
    localparam int C_VD = 5, C_EEW = 6, C_RDEN = 7, C_WREN = 8, C_MODE = 9;
    localparam int C_SREG = 10, C_VREG = 11, C_IMM = 12, C_RS1 = 13, C_RS2 = 14;
    localparam int C_VSET = 15, C_KEEP = 16;

    logic       CLK = 1'b0;
    logic       nRST;
    logic       instr_valid, instr_ready;
    instr_t     instr;
    evl_t       vl;
    vsew_t      vsew;
    logic       credit_return = 1'b0;
    logic       uop_valid, uop_last;
    uop_cnt_t   uop_num;
    regidx_t    uop_vd, uop_vs1, uop_vs2;
    vsew_t      uop_eew_dest, uop_eew_src2;
    funct6_t    uop_funct6;
    logic       uop_memdren, uop_memdwen;
    mop_t       uop_mode;
    logic       uop_sregwen, uop_vregwen;
    logic       uop_use_imm, uop_use_rs1, uop_use_rs2;
    vset_type_t uop_vset_type;
    logic       uop_keepvl;

    // Stimulus table and run bookkeeping
    int    tab [MAX_LINES][NCOL];
    int    n_lines = 0;
    int    errors = 0;
    int    total_uops = 0;
    int    cycle = 0;
    int    watchdog_cycles = 0;
    int    cur = 0;
    int    uop_seen = 0;
    logic  last_seen = 1'b0;
    string ctx = "reset";
    // Due cycle of each outstanding credit, oldest first
    int    due_q[$];

    vector_control_unit uut (.*);

    always #5 CLK = ~CLK;

    always @(posedge CLK) cycle <= cycle + 1;

    task automatic report_mismatch(input string what, input int got, input int exp);
        errors++;
        $display("FAILED at %0t: %s %s is %0d, expected %0d", $time, ctx, what, got, exp);
    endtask

    // Indexed loads and stores read their index vector at the memory width
    function automatic int expected_eew_src2(input logic [31:0] w, input int sew);
        logic is_mem;
        int   eew;
        is_mem = (w[6:0] == 7'b0000111) || (w[6:0] == 7'b0100111);
        eew    = sew;
        if (is_mem && w[26]) begin
            case (w[14:12])
                3'b000:  eew = 0;
                3'b101:  eew = 1;
                default: eew = 2;
            endcase
        end
        return eew;
    endfunction

    task automatic load_vectors();
        int    fd;
        int    got;
        string line;
        fd = $fopen("tb/vctrl_input.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the stimulus file tb/vctrl_input.txt");
        end else begin
            while (!$feof(fd) && n_lines < MAX_LINES) begin
                line = "";
                got = $fgets(line, fd);
                // Skip blank and comment lines
                if (got > 0 && line.len() > 1 && line[0] != "#") begin
                    got = $sscanf(line, "%h %h %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                        tab[n_lines][0], tab[n_lines][1], tab[n_lines][2], tab[n_lines][3],
                        tab[n_lines][4], tab[n_lines][5], tab[n_lines][6], tab[n_lines][7],
                        tab[n_lines][8], tab[n_lines][9], tab[n_lines][10],
                        tab[n_lines][11], tab[n_lines][12], tab[n_lines][13],
                        tab[n_lines][14], tab[n_lines][15], tab[n_lines][16]);
                    if (got == NCOL) begin
                        n_lines++;
                    end else begin
                        errors++;
                        $display("Malformed line in the stimulus file: %s", line);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Credit model, returns at most one credit per cycle once it falls due
    always @(posedge CLK) begin : credit_model
        int dropped;
        #1;
        if (due_q.size() != 0 && due_q[0] <= cycle) begin
            credit_return = 1'b1;
            dropped = due_q.pop_front();
        end else begin
            credit_return = 1'b0;
        end
    end

    // Every uop_valid cycle is one transfer, checked mid-cycle
    always @(negedge CLK) begin : uop_monitor
        logic [31:0] w;
        int          idx;
        int          step;
        int          base_vs1;
        int          exp_src2;
        if (nRST === 1'b1 && uop_valid === 1'b1) begin
            w   = tab[cur][C_INSTR];
            idx = uop_seen;
            // vset* keeps its register fields on every micro-op
            step     = (tab[cur][C_VSET] != 0) ? 0 : idx;
            // Store data comes from the vd field
            base_vs1 = (tab[cur][C_WREN] != 0) ? w[11:7] : w[19:15];
            exp_src2 = expected_eew_src2(w, tab[cur][C_VSEW]);
            if (idx >= tab[cur][C_COUNT]) begin
                errors++;
                $display("Extra micro-op at %0t beyond the %0d expected for %s",
                         $time, tab[cur][C_COUNT], ctx);
            end else begin
                if (uop_num !== idx) report_mismatch("uop_num", uop_num, idx);
                if (uop_vd !== ((tab[cur][C_VD] + step) & 31))
                    report_mismatch("vd", uop_vd, (tab[cur][C_VD] + step) & 31);
                if (uop_vs1 !== ((base_vs1 + step) & 31))
                    report_mismatch("vs1", uop_vs1, (base_vs1 + step) & 31);
                if (uop_vs2 !== ((w[24:20] + step) & 31))
                    report_mismatch("vs2", uop_vs2, (w[24:20] + step) & 31);
                if (uop_eew_dest !== tab[cur][C_EEW])
                    report_mismatch("eew_dest", uop_eew_dest, tab[cur][C_EEW]);
                if (uop_eew_src2 !== exp_src2)
                    report_mismatch("eew_src2", uop_eew_src2, exp_src2);
                if (uop_funct6 !== w[31:26]) report_mismatch("funct6", uop_funct6, w[31:26]);
                if (uop_memdren !== tab[cur][C_RDEN])
                    report_mismatch("memdren", uop_memdren, tab[cur][C_RDEN]);
                if (uop_memdwen !== tab[cur][C_WREN])
                    report_mismatch("memdwen", uop_memdwen, tab[cur][C_WREN]);
                if (uop_mode !== tab[cur][C_MODE])
                    report_mismatch("mode", uop_mode, tab[cur][C_MODE]);
                if (uop_sregwen !== tab[cur][C_SREG])
                    report_mismatch("sregwen", uop_sregwen, tab[cur][C_SREG]);
                if (uop_vregwen !== tab[cur][C_VREG])
                    report_mismatch("vregwen", uop_vregwen, tab[cur][C_VREG]);
                if (uop_use_imm !== tab[cur][C_IMM])
                    report_mismatch("use_imm", uop_use_imm, tab[cur][C_IMM]);
                if (uop_use_rs1 !== tab[cur][C_RS1])
                    report_mismatch("use_rs1", uop_use_rs1, tab[cur][C_RS1]);
                if (uop_use_rs2 !== tab[cur][C_RS2])
                    report_mismatch("use_rs2", uop_use_rs2, tab[cur][C_RS2]);
                if (uop_vset_type !== tab[cur][C_VSET])
                    report_mismatch("vset_type", uop_vset_type, tab[cur][C_VSET]);
                if (uop_keepvl !== tab[cur][C_KEEP])
                    report_mismatch("keepvl", uop_keepvl, tab[cur][C_KEEP]);
                // Last flag only on the final counted micro-op
                if (uop_last !== (idx == tab[cur][C_COUNT] - 1))
                    report_mismatch("uop_last", uop_last, idx == tab[cur][C_COUNT] - 1);
            end
            // Credit returned this cycle is already off the queue
            if (due_q.size() >= `NUM_CREDITS) begin
                errors++;
                $display("Credit overrun at %0t: more than %0d micro-ops outstanding",
                         $time, `NUM_CREDITS);
            end
            due_q.push_back(cycle + tab[cur][C_DELAY]);
            uop_seen++;
            total_uops++;
            if (uop_last === 1'b1) last_seen = 1'b1;
        end
    end

    task automatic run_instruction(input int i);
        @(posedge CLK);
        #1;
        cur         = i;
        uop_seen    = 0;
        last_seen   = 1'b0;
        ctx         = $sformatf("line %0d (%08h)", i + 1, tab[i][C_INSTR]);
        instr_valid = 1'b1;
        instr       = tab[i][C_INSTR];
        vl          = tab[i][C_VL];
        vsew        = vsew_t'(tab[i][C_VSEW]);
        // Hold the word until the sequencer is ready
        @(negedge CLK);
        while (instr_ready !== 1'b1) @(negedge CLK);
        @(posedge CLK);
        #1;
        instr_valid = 1'b0;
        if (tab[i][C_COUNT] == 0) begin
            // Dropped word, sequencer stays idle
            @(negedge CLK);
            if (instr_ready !== 1'b1) report_mismatch("instr_ready", instr_ready, 1);
            if (uop_valid !== 1'b0) report_mismatch("uop_valid", uop_valid, 0);
        end else begin
            while (!last_seen) @(posedge CLK);
            // Ready returns in the cycle after the last transfer
            @(negedge CLK);
            if (instr_ready !== 1'b1) report_mismatch("instr_ready", instr_ready, 1);
            if (uop_seen != tab[i][C_COUNT])
                report_mismatch("micro-op count", uop_seen, tab[i][C_COUNT]);
        end
    endtask

    initial begin
        int max_delay;
        nRST        = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        vl          = '0;
        vsew        = SEW8;
        load_vectors();
        max_delay = 0;
        for (int i = 0; i < n_lines; i++) begin
            if (tab[i][C_DELAY] > max_delay) max_delay = tab[i][C_DELAY];
        end
        // Per-line budget doubled for credit stalls
        watchdog_cycles = n_lines * (`MAX_UOPS + max_delay) * 2 + RESET_CYCLES + 10;
        repeat (RESET_CYCLES) @(posedge CLK);
        #1;
        nRST = 1'b1;
        @(negedge CLK);
        if (instr_ready !== 1'b1) report_mismatch("instr_ready", instr_ready, 1);
        if (uop_valid !== 1'b0) report_mismatch("uop_valid", uop_valid, 0);
        for (int i = 0; i < n_lines; i++) begin
            run_instruction(i);
        end
        // Let every outstanding credit come home
        while (due_q.size() != 0) @(posedge CLK);
        @(negedge CLK);
        $display("Run finished: %0d instructions, %0d micro-ops, %0d errors",
                 n_lines, total_uops, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Watchdog sized from the stimulus length
    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge CLK);
        $display("Timeout: the run did not finish within %0d cycles", watchdog_cycles);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: Bender.yml
package:
  name: vctrl

export_include_dirs:
  - design

sources:
  - design/vinstr_pkg.sv
  - design/vuop_pkg.sv
  - design/vdec_if.sv
  - design/vinstr_decode.sv
  - design/vwidth_calc.sv
  - design/vuop_seq.sv
  - design/vector_control_unit.sv
  - target: test
    files:
      - tb/tb_vector_control_unit.sv

// File: vctrl.f
+incdir+design
design/vinstr_pkg.sv
design/vuop_pkg.sv
design/vdec_if.sv
design/vinstr_decode.sv
design/vwidth_calc.sv
design/vuop_seq.sv
design/vector_control_unit.sv
tb/tb_vector_control_unit.sv

// File: tb/vctrl_input.txt
# instr(hex) vl(hex) vsew delay | exp: count vd eew_dest memdren memdwen mode
#   sregwen vregwen use_imm use_rs1 use_rs2 vset_type keepvl
02056407 10 2 2 4 8 2 1 0 0 0 1 0 1 1 0 0
02058207 14 2 1 2 4 0 1 0 0 0 1 0 1 1 0 0
0A62D107 1e 0 3 4 2 1 1 0 2 0 1 0 1 1 0 0
0E408807 08 2 1 2 16 2 1 0 3 0 1 0 1 0 0 0
02B10007 11 2 1 1 0 0 1 0 0 0 1 0 1 1 0 0
2281E207 05 0 2 2 4 2 1 0 0 0 1 0 1 1 0 0
0203D627 18 2 4 3 12 1 0 1 0 0 0 0 1 1 0 0
0A946A27 28 0 6 8 20 2 0 1 2 0 0 0 1 1 0 0
06225427 0c 1 1 2 8 1 0 1 1 0 0 0 1 0 0 0
02B280A7 40 2 2 1 1 0 0 1 0 0 0 0 1 1 0 0
62830427 07 1 5 4 8 0 0 1 0 0 0 0 1 1 0 0
02860257 20 1 3 4 4 1 0 0 0 0 1 0 0 0 0 0
0262B157 08 2 1 2 2 2 0 0 0 0 1 1 0 0 0 0
C641E457 28 0 6 5 8 1 0 0 1 0 1 0 1 0 0 0
E34C2857 10 1 2 4 16 2 0 0 0 0 1 0 0 0 0 0
C2222557 04 2 1 2 10 3 0 0 0 0 1 0 0 0 0 0
010372D7 10 0 1 1 5 0 0 0 0 1 0 0 0 0 1 0
01007057 10 1 2 1 0 1 0 0 0 1 0 0 0 0 1 1
C00273D7 10 2 1 1 7 2 0 0 0 1 0 0 0 0 2 0
80907057 10 0 1 1 0 0 0 0 0 1 0 0 0 0 3 1
00100093 10 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0
02860257 00 0 3 1 4 0 0 0 0 0 1 0 0 0 0 0
